// ==== hw/lane.sv ====
// Lane top: sequencer, operand requester, register file, operand and result queues, ALU
`timescale 1ns/1ps
`default_nettype none

module lane (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Instruction port
  input  logic              pe_req_valid_i,
  output logic              pe_req_ready_o,
  input  lane_pkg::alu_op_e op_i,
  input  lane_pkg::vreg_t   vs1_i,
  input  lane_pkg::vreg_t   vs2_i,
  input  lane_pkg::vreg_t   vd_i,
  input  lane_pkg::vl_t     vl_i,
  output logic              vinsn_done_o,
  // Load unit
  input  logic              ldu_req_i,
  input  lane_pkg::vreg_t   ldu_vreg_i,
  input  lane_pkg::velem_t  ldu_elem_i,
  input  lane_pkg::elen_t   ldu_wdata_i,
  output logic              ldu_gnt_o,
  // Store unit
  output lane_pkg::elen_t   stu_operand_o,
  output logic              stu_operand_valid_o,
  input  logic              stu_operand_ready_i
);

  logic                                    launch;
  lane_pkg::alu_op_e                       op;
  lane_pkg::vreg_t                         vs1;
  lane_pkg::vreg_t                         vs2;
  lane_pkg::vreg_t                         vd;
  lane_pkg::vl_t                           vl;
  logic                                    elem_done;
  logic                                    stu_hs;
  lane_pkg::wb_req_t                       alu_wb;
  logic                                    alu_wb_valid;
  logic                                    alu_wb_gnt;
  logic            [lane_pkg::NrBanks-1:0] vrf_req;
  logic            [lane_pkg::NrBanks-1:0] vrf_wen;
  lane_pkg::vaddr_t [lane_pkg::NrBanks-1:0] vrf_addr;
  lane_pkg::elen_t [lane_pkg::NrBanks-1:0] vrf_wdata;
  lane_pkg::opq_e  [lane_pkg::NrBanks-1:0] vrf_tgt;
  lane_pkg::elen_t [lane_pkg::NrOpqs-1:0]  vrf_operand;
  logic            [lane_pkg::NrOpqs-1:0]  vrf_operand_valid;
  lane_pkg::elen_t [lane_pkg::NrOpqs-1:0]  opq_data;
  logic            [lane_pkg::NrOpqs-1:0]  opq_valid;
  logic            [lane_pkg::NrOpqs-1:0]  opq_pop;
  logic                                    alu_pop;
  logic                                    res_push;
  logic                                    res_full;
  lane_pkg::wb_req_t                       res;

  assign stu_hs              = stu_operand_valid_o && stu_operand_ready_i;
  assign stu_operand_o       = opq_data[lane_pkg::STU];
  assign stu_operand_valid_o = opq_valid[lane_pkg::STU];
  // Stores complete on the port, ALU ops on write-back
  assign elem_done           = (op == lane_pkg::STORE) ? stu_hs : alu_wb_gnt;
  assign opq_pop             = {stu_hs, alu_pop, alu_pop};

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  lane_sequencer u_sequencer (
    .clk_i          (clk_i         ),
    .rst_ni         (rst_ni        ),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .op_i           (op_i          ),
    .vs1_i          (vs1_i         ),
    .vs2_i          (vs2_i         ),
    .vd_i           (vd_i          ),
    .vl_i           (vl_i          ),
    .launch_o       (launch        ),
    .op_o           (op            ),
    .vs1_o          (vs1           ),
    .vs2_o          (vs2           ),
    .vd_o           (vd            ),
    .vl_o           (vl            ),
    .elem_done_i    (elem_done     ),
    .vinsn_done_o   (vinsn_done_o  )
  );

  operand_requester u_requester (
    .clk_i          (clk_i       ),
    .rst_ni         (rst_ni      ),
    .launch_i       (launch      ),
    .op_i           (op          ),
    .vs1_i          (vs1         ),
    .vs2_i          (vs2         ),
    .vl_i           (vl          ),
    .opq_pop_i      (opq_pop     ),
    .alu_wb_i       (alu_wb      ),
    .alu_wb_valid_i (alu_wb_valid),
    .alu_wb_gnt_o   (alu_wb_gnt  ),
    .ldu_req_i      (ldu_req_i   ),
    .ldu_vreg_i     (ldu_vreg_i  ),
    .ldu_elem_i     (ldu_elem_i  ),
    .ldu_wdata_i    (ldu_wdata_i ),
    .ldu_gnt_o      (ldu_gnt_o   ),
    .vrf_req_o      (vrf_req     ),
    .vrf_wen_o      (vrf_wen     ),
    .vrf_addr_o     (vrf_addr    ),
    .vrf_wdata_o    (vrf_wdata   ),
    .vrf_tgt_o      (vrf_tgt     )
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  vector_regfile u_vrf (
    .clk_i           (clk_i            ),
    .rst_ni          (rst_ni           ),
    .req_i           (vrf_req          ),
    .wen_i           (vrf_wen          ),
    .addr_i          (vrf_addr         ),
    .wdata_i         (vrf_wdata        ),
    .tgt_i           (vrf_tgt          ),
    .operand_o       (vrf_operand      ),
    .operand_valid_o (vrf_operand_valid)
  );

  // Credits in the requester keep these from overflowing
  for (genvar q = 0; q < lane_pkg::NrOpqs; q++) begin : gen_opq
    lane_fifo #(
      .T     (lane_pkg::elen_t  ),
      .Depth (lane_pkg::OpqDepth)
    ) u_opq (
      .clk_i   (clk_i               ),
      .rst_ni  (rst_ni              ),
      .push_i  (vrf_operand_valid[q]),
      .data_i  (vrf_operand[q]      ),
      .full_o  (                    ),
      .pop_i   (opq_pop[q]          ),
      .data_o  (opq_data[q]         ),
      .valid_o (opq_valid[q]        )
    );
  end

  lane_alu u_alu (
    .clk_i       (clk_i                     ),
    .rst_ni      (rst_ni                    ),
    .launch_i    (launch                    ),
    .op_i        (op                        ),
    .vd_i        (vd                        ),
    .opa_i       (opq_data[lane_pkg::ALU_A] ),
    .opb_i       (opq_data[lane_pkg::ALU_B] ),
    .opa_valid_i (opq_valid[lane_pkg::ALU_A]),
    .opb_valid_i (opq_valid[lane_pkg::ALU_B]),
    .op_pop_o    (alu_pop                   ),
    .res_full_i  (res_full                  ),
    .res_push_o  (res_push                  ),
    .res_o       (res                       )
  );

  // Results wait here for a free bank
  lane_fifo #(
    .T     (lane_pkg::wb_req_t),
    .Depth (lane_pkg::OpqDepth)
  ) u_resq (
    .clk_i   (clk_i       ),
    .rst_ni  (rst_ni      ),
    .push_i  (res_push    ),
    .data_i  (res         ),
    .full_o  (res_full    ),
    .pop_i   (alu_wb_gnt  ),
    .data_o  (alu_wb      ),
    .valid_o (alu_wb_valid)
  );

endmodule

`default_nettype wire

// ==== hw/lane_alu.sv ====
// Integer ALU: pops operand pairs and pushes tagged results to the result queue
`timescale 1ns/1ps
`default_nettype none

module lane_alu (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              launch_i,
  input  lane_pkg::alu_op_e op_i,
  input  lane_pkg::vreg_t   vd_i,
  input  lane_pkg::elen_t   opa_i,
  input  lane_pkg::elen_t   opb_i,
  input  logic              opa_valid_i,
  input  logic              opb_valid_i,
  output logic              op_pop_o,
  input  logic              res_full_i,
  output logic              res_push_o,
  output lane_pkg::wb_req_t res_o
);

  logic             fire;
  lane_pkg::velem_t elem_q;
  lane_pkg::elen_t  result;

  // Both operands present and room for the result
  assign fire       = opa_valid_i && opb_valid_i && !res_full_i;
  assign op_pop_o   = fire;
  assign res_push_o = fire;

  always_comb begin
    case (op_i)
      lane_pkg::ADD: result = opa_i + opb_i;
      lane_pkg::SUB: result = opa_i - opb_i;
      lane_pkg::AND: result = opa_i & opb_i;
      lane_pkg::OR:  result = opa_i | opb_i;
      lane_pkg::XOR: result = opa_i ^ opb_i;
      // Stores bypass the ALU
      default:       result = '0;
    endcase
  end

  assign res_o = '{vreg: vd_i, elem: elem_q, data: result};

  // Operands arrive in element order
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elem_q <= '0;
    end else if (launch_i) begin
      elem_q <= '0;
    end else if (fire) begin
      elem_q <= elem_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lane_fifo.sv ====
// Circular first-word-fall-through queue with a type parameter for its payload
`timescale 1ns/1ps
`default_nettype none

module lane_fifo #(
  parameter type         T     = logic,
  // Power of two, so the pointers wrap on their own
  parameter int unsigned Depth = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  input  logic pop_i,
  output T     data_o,
  output logic valid_o
);

  T                           mem_q [Depth];
  logic [$clog2(Depth)-1:0]   wr_ptr_q;
  logic [$clog2(Depth)-1:0]   rd_ptr_q;
  logic [$clog2(Depth+1)-1:0] count_q;
  logic                       do_push;
  logic                       do_pop;

  assign full_o  = (count_q == Depth);
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + do_push - do_pop;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lane_pkg.sv ====
// Lane sizes, element and address types, ALU and queue encodings, write-back payload
`default_nettype none

package lane_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int unsigned NrVRegs   = 8;
  localparam int unsigned MaxVl     = 8;
  localparam int unsigned NrBanks   = 4;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned OpqDepth  = 4;
  // ALU_A, ALU_B and STU
  localparam int unsigned NrOpqs    = 3;
  // Elements held by one bank
  localparam int unsigned BankDepth = NrVRegs * MaxVl / NrBanks;

  //////////////////////////////////////////////////
  // Element and address types
  //////////////////////////////////////////////////

  typedef logic [DataWidth-1:0]         elen_t;
  typedef logic [$clog2(NrVRegs)-1:0]   vreg_t;
  typedef logic [$clog2(MaxVl)-1:0]     velem_t;
  // Zero up to MaxVl inclusive
  typedef logic [$clog2(MaxVl+1)-1:0]   vl_t;
  typedef logic [$clog2(NrBanks)-1:0]   bank_t;
  // Register index and upper element bit
  typedef logic [$clog2(BankDepth)-1:0] vaddr_t;

  //////////////////////////////////////////////////
  // Encodings and payloads
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ADD   = 3'd0,
    SUB   = 3'd1,
    AND   = 3'd2,
    OR    = 3'd3,
    XOR   = 3'd4,
    STORE = 3'd5
  } alu_op_e;

  typedef enum logic [1:0] {
    ALU_A = 2'd0,
    ALU_B = 2'd1,
    STU   = 2'd2
  } opq_e;

  // ALU result on its way back to the register file
  typedef struct packed {
    vreg_t  vreg;
    velem_t elem;
    elen_t  data;
  } wb_req_t;

endpackage

`default_nettype wire

// ==== hw/lane_sequencer.sv ====
// Lane sequencer: instruction accept, launch pulse, element completion count and done
`timescale 1ns/1ps
`default_nettype none

module lane_sequencer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              pe_req_valid_i,
  output logic              pe_req_ready_o,
  input  lane_pkg::alu_op_e op_i,
  input  lane_pkg::vreg_t   vs1_i,
  input  lane_pkg::vreg_t   vs2_i,
  input  lane_pkg::vreg_t   vd_i,
  input  lane_pkg::vl_t     vl_i,
  output logic              launch_o,
  output lane_pkg::alu_op_e op_o,
  output lane_pkg::vreg_t   vs1_o,
  output lane_pkg::vreg_t   vs2_o,
  output lane_pkg::vreg_t   vd_o,
  output lane_pkg::vl_t     vl_o,
  input  logic              elem_done_i,
  output logic              vinsn_done_o
);

  logic          busy_q;
  lane_pkg::vl_t cnt_q;
  logic          accept;
  logic          last;

  assign pe_req_ready_o = !busy_q;
  assign accept         = pe_req_valid_i && !busy_q;
  // Final element of the running instruction completes this cycle
  assign last           = busy_q && elem_done_i && (cnt_q + 1'b1 == vl_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      cnt_q        <= '0;
      launch_o     <= 1'b0;
      vinsn_done_o <= 1'b0;
      op_o         <= lane_pkg::ADD;
      vs1_o        <= '0;
      vs2_o        <= '0;
      vd_o         <= '0;
      vl_o         <= '0;
    end else begin
      launch_o     <= accept;
      // An empty instruction finishes right away
      vinsn_done_o <= last || (accept && vl_i == '0);
      if (accept) begin
        busy_q <= (vl_i != '0);
        cnt_q  <= '0;
        op_o   <= op_i;
        vs1_o  <= vs1_i;
        vs2_o  <= vs2_i;
        vd_o   <= vd_i;
        vl_o   <= vl_i;
      end else if (last) begin
        busy_q <= 1'b0;
      end else if (busy_q && elem_done_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/operand_requester.sv ====
// Operand requester: per-bank read/write arbitration, element counters and queue credits
`timescale 1ns/1ps
`default_nettype none

module operand_requester (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     launch_i,
  input  lane_pkg::alu_op_e                        op_i,
  input  lane_pkg::vreg_t                          vs1_i,
  input  lane_pkg::vreg_t                          vs2_i,
  input  lane_pkg::vl_t                            vl_i,
  input  logic             [lane_pkg::NrOpqs-1:0]  opq_pop_i,
  input  lane_pkg::wb_req_t                        alu_wb_i,
  input  logic                                     alu_wb_valid_i,
  output logic                                     alu_wb_gnt_o,
  input  logic                                     ldu_req_i,
  input  lane_pkg::vreg_t                          ldu_vreg_i,
  input  lane_pkg::velem_t                         ldu_elem_i,
  input  lane_pkg::elen_t                          ldu_wdata_i,
  output logic                                     ldu_gnt_o,
  output logic             [lane_pkg::NrBanks-1:0] vrf_req_o,
  output logic             [lane_pkg::NrBanks-1:0] vrf_wen_o,
  output lane_pkg::vaddr_t [lane_pkg::NrBanks-1:0] vrf_addr_o,
  output lane_pkg::elen_t  [lane_pkg::NrBanks-1:0] vrf_wdata_o,
  output lane_pkg::opq_e   [lane_pkg::NrBanks-1:0] vrf_tgt_o
);

  typedef logic [$clog2(lane_pkg::OpqDepth+1)-1:0] credit_t;

  lane_pkg::vl_t               cnt_q    [lane_pkg::NrOpqs];
  credit_t                     credit_q [lane_pkg::NrOpqs];
  lane_pkg::vreg_t             rd_vreg  [lane_pkg::NrOpqs];
  lane_pkg::velem_t            rd_elem  [lane_pkg::NrOpqs];
  logic [lane_pkg::NrOpqs-1:0] rd_used;
  logic [lane_pkg::NrOpqs-1:0] rd_req;
  logic [lane_pkg::NrOpqs-1:0] rd_gnt;

  // Consecutive elements of a register rotate through the banks
  function automatic lane_pkg::bank_t bank_of(input lane_pkg::vreg_t  vreg,
                                              input lane_pkg::velem_t elem);
    return lane_pkg::bank_t'(vreg) + lane_pkg::bank_t'(elem);
  endfunction

  function automatic lane_pkg::vaddr_t addr_of(input lane_pkg::vreg_t  vreg,
                                               input lane_pkg::velem_t elem);
    return {vreg, elem[$bits(lane_pkg::velem_t)-1]};
  endfunction

  //////////////////////////////////////////////////
  // Read requests
  //////////////////////////////////////////////////

  assign rd_vreg[lane_pkg::ALU_A] = vs1_i;
  assign rd_vreg[lane_pkg::ALU_B] = vs2_i;
  assign rd_vreg[lane_pkg::STU]   = vs2_i;

  assign rd_used[lane_pkg::ALU_A] = (op_i != lane_pkg::STORE);
  assign rd_used[lane_pkg::ALU_B] = (op_i != lane_pkg::STORE);
  assign rd_used[lane_pkg::STU]   = (op_i == lane_pkg::STORE);

  // Counters still hold the last instruction during the launch cycle
  always_comb begin
    for (int q = 0; q < lane_pkg::NrOpqs; q++) begin
      rd_elem[q] = lane_pkg::velem_t'(cnt_q[q]);
      rd_req[q]  = rd_used[q] && !launch_i && (cnt_q[q] < vl_i) && (credit_q[q] != '0);
    end
  end

  //////////////////////////////////////////////////
  // Bank arbitration
  //////////////////////////////////////////////////

  // Load write, then ALU write, then reads in queue order
  always_comb begin
    lane_pkg::bank_t ldu_bank;
    lane_pkg::bank_t wb_bank;
    logic            taken;
    ldu_bank     = bank_of(ldu_vreg_i, ldu_elem_i);
    wb_bank      = bank_of(alu_wb_i.vreg, alu_wb_i.elem);
    vrf_req_o    = '0;
    vrf_wen_o    = '0;
    vrf_addr_o   = '0;
    vrf_wdata_o  = '0;
    ldu_gnt_o    = 1'b0;
    alu_wb_gnt_o = 1'b0;
    rd_gnt       = '0;
    for (int b = 0; b < lane_pkg::NrBanks; b++) begin
      vrf_tgt_o[b] = lane_pkg::ALU_A;
      taken        = 1'b1;
      if (ldu_req_i && ldu_bank == lane_pkg::bank_t'(b)) begin
        vrf_wen_o[b]   = 1'b1;
        vrf_addr_o[b]  = addr_of(ldu_vreg_i, ldu_elem_i);
        vrf_wdata_o[b] = ldu_wdata_i;
        ldu_gnt_o      = 1'b1;
      end else if (alu_wb_valid_i && wb_bank == lane_pkg::bank_t'(b)) begin
        vrf_wen_o[b]   = 1'b1;
        vrf_addr_o[b]  = addr_of(alu_wb_i.vreg, alu_wb_i.elem);
        vrf_wdata_o[b] = alu_wb_i.data;
        alu_wb_gnt_o   = 1'b1;
      end else begin
        taken = 1'b0;
      end
      for (int q = 0; q < lane_pkg::NrOpqs; q++) begin
        if (!taken && rd_req[q] && bank_of(rd_vreg[q], rd_elem[q]) == lane_pkg::bank_t'(b)) begin
          taken         = 1'b1;
          vrf_addr_o[b] = addr_of(rd_vreg[q], rd_elem[q]);
          vrf_tgt_o[b]  = lane_pkg::opq_e'(q);
          rd_gnt[q]     = 1'b1;
        end
      end
      vrf_req_o[b] = taken;
    end
  end

  //////////////////////////////////////////////////
  // Counters and credits
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int q = 0; q < lane_pkg::NrOpqs; q++) begin
        cnt_q[q]    <= '0;
        credit_q[q] <= credit_t'(lane_pkg::OpqDepth);
      end
    end else begin
      for (int q = 0; q < lane_pkg::NrOpqs; q++) begin
        if (launch_i) begin
          cnt_q[q] <= '0;
        end else if (rd_gnt[q]) begin
          cnt_q[q] <= cnt_q[q] + 1'b1;
        end
        // Taken on issue, given back when the queue pops
        credit_q[q] <= credit_q[q] - rd_gnt[q] + opq_pop_i[q];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/vector_regfile.sv ====
// Banked vector register file with registered reads steered to the operand queues
`timescale 1ns/1ps
`default_nettype none

module vector_regfile (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic             [lane_pkg::NrBanks-1:0] req_i,
  input  logic             [lane_pkg::NrBanks-1:0] wen_i,
  input  lane_pkg::vaddr_t [lane_pkg::NrBanks-1:0] addr_i,
  input  lane_pkg::elen_t  [lane_pkg::NrBanks-1:0] wdata_i,
  input  lane_pkg::opq_e   [lane_pkg::NrBanks-1:0] tgt_i,
  output lane_pkg::elen_t  [lane_pkg::NrOpqs-1:0]  operand_o,
  output logic             [lane_pkg::NrOpqs-1:0]  operand_valid_o
);

  lane_pkg::elen_t                         mem_q [lane_pkg::NrBanks][lane_pkg::BankDepth];
  lane_pkg::elen_t [lane_pkg::NrBanks-1:0] rdata_q;
  lane_pkg::opq_e  [lane_pkg::NrBanks-1:0] tgt_q;
  logic            [lane_pkg::NrBanks-1:0] rvalid_q;

  // One access per bank and cycle
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < lane_pkg::NrBanks; b++) begin
      if (req_i[b] && wen_i[b]) begin
        mem_q[b][addr_i[b]] <= wdata_i[b];
      end
      if (req_i[b] && !wen_i[b]) begin
        rdata_q[b] <= mem_q[b][addr_i[b]];
        tgt_q[b]   <= tgt_i[b];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q <= req_i & ~wen_i;
    end
  end

  // Each queue reads at most one bank per cycle
  always_comb begin
    operand_o       = '0;
    operand_valid_o = '0;
    for (int b = 0; b < lane_pkg::NrBanks; b++) begin
      if (rvalid_q[b]) begin
        operand_o[tgt_q[b]]       = rdata_q[b];
        operand_valid_o[tgt_q[b]] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the lane testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD=build
LOG="$BUILD/sim.log"
FAIL_MSG="Simulation finished: FAIL"

mkdir -p "$BUILD"
if [ $? -ne 0 ]; then
  echo "Cannot create the build directory"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal --top-module tb_lane \
  -f sources.f -Mdir "$BUILD/obj_dir" -o tb_lane
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$BUILD/obj_dir/tb_lane" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
  exit 1
fi
exit 0

// ==== sim/tb_lane.sv ====
// Lane testbench: clock, reset, step table, shadow register file, compare tasks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_lane;

  localparam int unsigned NrSteps    = 19;
  localparam int unsigned StepCycles = 200;
  localparam logic [31:0] Seed       = 32'h91cebbac;

  typedef enum logic {STEP_LOAD, STEP_INSN} kind_e;

  // ldv is the register written through the load port while an instruction runs
  typedef struct packed {
    kind_e             kind;
    lane_pkg::alu_op_e op;
    lane_pkg::vreg_t   vs1;
    lane_pkg::vreg_t   vs2;
    lane_pkg::vreg_t   vd;
    lane_pkg::vl_t     vl;
    logic              loads;
    lane_pkg::vreg_t   ldv;
    logic              rand_ready;
  } step_t;

  logic              clk_i;
  logic              rst_ni;
  logic              pe_req_valid_i;
  logic              pe_req_ready_o;
  lane_pkg::alu_op_e op_i;
  lane_pkg::vreg_t   vs1_i;
  lane_pkg::vreg_t   vs2_i;
  lane_pkg::vreg_t   vd_i;
  lane_pkg::vl_t     vl_i;
  logic              vinsn_done_o;
  logic              ldu_req_i;
  lane_pkg::vreg_t   ldu_vreg_i;
  lane_pkg::velem_t  ldu_elem_i;
  lane_pkg::elen_t   ldu_wdata_i;
  logic              ldu_gnt_o;
  lane_pkg::elen_t   stu_operand_o;
  logic              stu_operand_valid_o;
  logic              stu_operand_ready_i;

  step_t           steps [NrSteps];
  lane_pkg::elen_t shadow [lane_pkg::NrVRegs][lane_pkg::MaxVl];
  logic [31:0]     rng;
  int              n_tests;
  int              n_failed;
  int              n_checks;
  int              n_errors;
  int              step_errors;

  lane u_lane (.*);

  bind lane tb_lane_sva u_lane_sva (
    .clk_i               (clk_i              ),
    .rst_ni              (rst_ni             ),
    .stu_operand_i       (stu_operand_o      ),
    .stu_operand_valid_i (stu_operand_valid_o),
    .stu_operand_ready_i (stu_operand_ready_i),
    .vinsn_done_i        (vinsn_done_o       ),
    .ldu_req_i           (ldu_req_i          ),
    .ldu_gnt_i           (ldu_gnt_o          )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reference for vd[i] = vs1[i] op vs2[i]
  function automatic lane_pkg::elen_t alu_ref(input lane_pkg::alu_op_e op,
                                              input lane_pkg::elen_t   a,
                                              input lane_pkg::elen_t   b);
    case (op)
      lane_pkg::ADD: return a + b;
      lane_pkg::SUB: return a - b;
      lane_pkg::AND: return a & b;
      lane_pkg::OR:  return a | b;
      lane_pkg::XOR: return a ^ b;
      default:       return a;
    endcase
  endfunction

  ////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////

  task automatic check_elen(input string name, input lane_pkg::elen_t got,
                            input lane_pkg::elen_t exp);
    n_checks++;
    if (got !== exp) begin
      step_errors++;
      $display("Fail %s: expected 0x%08h, got 0x%08h", name, exp, got);
    end
  endtask

  task automatic check_count(input string name, input lane_pkg::vl_t got,
                             input lane_pkg::vl_t exp);
    n_checks++;
    if (got !== exp) begin
      step_errors++;
      $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, got);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      step_errors++;
      $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, got);
    end
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    n_errors += step_errors;
    if (step_errors != 0) begin
      n_failed++;
    end
    $display("%s: %s", name, (step_errors == 0) ? "ok" : "errors found");
  endtask

  ////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////

  task automatic load_reg(input lane_pkg::vreg_t vreg);
    for (int e = 0; e < int'(lane_pkg::MaxVl); e++) begin
      rng = xorshift(rng);
      @(posedge clk_i);
      ldu_req_i   <= 1'b1;
      ldu_vreg_i  <= vreg;
      ldu_elem_i  <= lane_pkg::velem_t'(e);
      ldu_wdata_i <= rng;
      shadow[vreg][e] = rng;
      @(negedge clk_i);
      while (!ldu_gnt_o) @(negedge clk_i);
    end
    @(posedge clk_i);
    ldu_req_i <= 1'b0;
  endtask

  task automatic run_insn(input step_t s);
    lane_pkg::elen_t stored [$];
    logic            done;
    int              ld_cnt;
    int              ld_drv;
    done   = 1'b0;
    ld_cnt = 0;
    ld_drv = 0;
    @(posedge clk_i);
    pe_req_valid_i <= 1'b1;
    op_i           <= s.op;
    vs1_i          <= s.vs1;
    vs2_i          <= s.vs2;
    vd_i           <= s.vd;
    vl_i           <= s.vl;
    @(negedge clk_i);
    check_flag("pe_req_ready_o", pe_req_ready_o, 1'b1);
    // Accepted on this edge
    @(posedge clk_i);
    pe_req_valid_i <= 1'b0;
    while (!done || (s.loads && ld_cnt < int'(lane_pkg::MaxVl))) begin
      if (s.rand_ready) begin
        rng = xorshift(rng);
        stu_operand_ready_i <= rng[0];
      end
      if (s.loads && ld_drv == ld_cnt && ld_cnt < int'(lane_pkg::MaxVl)) begin
        rng = xorshift(rng);
        ldu_req_i   <= 1'b1;
        ldu_vreg_i  <= s.ldv;
        ldu_elem_i  <= lane_pkg::velem_t'(ld_drv);
        ldu_wdata_i <= rng;
        shadow[s.ldv][ld_drv] = rng;
        ld_drv++;
      end else if (ld_drv == ld_cnt) begin
        ldu_req_i <= 1'b0;
      end
      @(negedge clk_i);
      if (stu_operand_valid_o && stu_operand_ready_i) begin
        stored.push_back(stu_operand_o);
      end
      if (ldu_req_i) begin
        // A load write wins its bank over every other access
        check_flag("ldu_gnt_o", ldu_gnt_o, 1'b1);
        if (ldu_gnt_o) begin
          ld_cnt++;
        end
      end
      if (vinsn_done_o) begin
        done = 1'b1;
      end
      @(posedge clk_i);
    end
    ldu_req_i           <= 1'b0;
    stu_operand_ready_i <= 1'b1;
    if (s.op == lane_pkg::STORE) begin
      check_count("stu handshakes", lane_pkg::vl_t'(stored.size()), s.vl);
      for (int i = 0; i < stored.size() && i < int'(s.vl); i++) begin
        check_elen($sformatf("stu_operand_o[%0d]", i), stored[i], shadow[s.vs2][i]);
      end
    end else begin
      check_count("stu handshakes", lane_pkg::vl_t'(stored.size()), '0);
      // Elements at or above vl keep their old value
      for (int i = 0; i < int'(s.vl); i++) begin
        shadow[s.vd][i] = alu_ref(s.op, shadow[s.vs1][i], shadow[s.vs2][i]);
      end
    end
  endtask

  ////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////

  initial begin
    rst_ni              = 1'b0;
    pe_req_valid_i      = 1'b0;
    op_i                = lane_pkg::ADD;
    vs1_i               = '0;
    vs2_i               = '0;
    vd_i                = '0;
    vl_i                = '0;
    ldu_req_i           = 1'b0;
    ldu_vreg_i          = '0;
    ldu_elem_i          = '0;
    ldu_wdata_i         = '0;
    stu_operand_ready_i = 1'b1;
    rng                 = Seed;
    n_tests             = 0;
    n_failed            = 0;
    n_checks            = 0;
    n_errors            = 0;

    // kind, op, vs1, vs2, vd, vl, loads, ldv, rand_ready
    steps[0]  = '{STEP_LOAD, lane_pkg::ADD,   3'd0, 3'd0, 3'd1, 4'd8, 1'b0, 3'd0, 1'b0};
    steps[1]  = '{STEP_LOAD, lane_pkg::ADD,   3'd0, 3'd0, 3'd2, 4'd8, 1'b0, 3'd0, 1'b0};
    steps[2]  = '{STEP_INSN, lane_pkg::STORE, 3'd0, 3'd1, 3'd0, 4'd8, 1'b0, 3'd0, 1'b0};
    steps[3]  = '{STEP_INSN, lane_pkg::ADD,   3'd1, 3'd2, 3'd3, 4'd8, 1'b0, 3'd0, 1'b0};
    steps[4]  = '{STEP_INSN, lane_pkg::STORE, 3'd0, 3'd3, 3'd0, 4'd8, 1'b0, 3'd0, 1'b0};
    steps[5]  = '{STEP_LOAD, lane_pkg::ADD,   3'd0, 3'd0, 3'd4, 4'd8, 1'b0, 3'd0, 1'b0};
    steps[6]  = '{STEP_INSN, lane_pkg::SUB,   3'd1, 3'd2, 3'd4, 4'd5, 1'b0, 3'd0, 1'b0};
    steps[7]  = '{STEP_INSN, lane_pkg::STORE, 3'd0, 3'd4, 3'd0, 4'd8, 1'b0, 3'd0, 1'b0};
    steps[8]  = '{STEP_LOAD, lane_pkg::ADD,   3'd0, 3'd0, 3'd5, 4'd8, 1'b0, 3'd0, 1'b0};
    steps[9]  = '{STEP_INSN, lane_pkg::AND,   3'd2, 3'd1, 3'd5, 4'd3, 1'b0, 3'd0, 1'b0};
    steps[10] = '{STEP_INSN, lane_pkg::STORE, 3'd0, 3'd5, 3'd0, 4'd8, 1'b0, 3'd0, 1'b1};
    steps[11] = '{STEP_INSN, lane_pkg::OR,    3'd1, 3'd3, 3'd6, 4'd8, 1'b1, 3'd7, 1'b0};
    steps[12] = '{STEP_INSN, lane_pkg::STORE, 3'd0, 3'd6, 3'd0, 4'd8, 1'b0, 3'd0, 1'b0};
    steps[13] = '{STEP_INSN, lane_pkg::STORE, 3'd0, 3'd7, 3'd0, 4'd8, 1'b0, 3'd0, 1'b1};
    steps[14] = '{STEP_INSN, lane_pkg::XOR,   3'd3, 3'd4, 3'd0, 4'd8, 1'b0, 3'd0, 1'b0};
    steps[15] = '{STEP_INSN, lane_pkg::STORE, 3'd0, 3'd0, 3'd0, 4'd8, 1'b0, 3'd0, 1'b1};
    steps[16] = '{STEP_INSN, lane_pkg::STORE, 3'd0, 3'd1, 3'd0, 4'd0, 1'b0, 3'd0, 1'b0};
    steps[17] = '{STEP_INSN, lane_pkg::ADD,   3'd1, 3'd2, 3'd3, 4'd0, 1'b0, 3'd0, 1'b0};
    steps[18] = '{STEP_INSN, lane_pkg::STORE, 3'd0, 3'd3, 3'd0, 4'd8, 1'b0, 3'd0, 1'b1};

    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    step_errors = 0;
    check_flag("pe_req_ready_o", pe_req_ready_o, 1'b1);
    check_flag("stu_operand_valid_o", stu_operand_valid_o, 1'b0);
    check_flag("ldu_gnt_o", ldu_gnt_o, 1'b0);
    check_flag("vinsn_done_o", vinsn_done_o, 1'b0);
    finish_test("reset");

    for (int i = 0; i < int'(NrSteps); i++) begin
      step_errors = 0;
      if (steps[i].kind == STEP_LOAD) begin
        load_reg(steps[i].vd);
      end else begin
        run_insn(steps[i]);
      end
      finish_test($sformatf("step %0d (%s)", i,
                            (steps[i].kind == STEP_LOAD) ? "load" : "instruction"));
    end

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (NrSteps * StepCycles) @(posedge clk_i);
    $display("Timeout: the steps did not complete within %0d cycles", NrSteps * StepCycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_lane_sva.sv ====
// Lane assertions: store port stability, done pulse width, load grants
`timescale 1ns/1ps
`default_nettype none

module tb_lane_sva (
  input logic            clk_i,
  input logic            rst_ni,
  input lane_pkg::elen_t stu_operand_i,
  input logic            stu_operand_valid_i,
  input logic            stu_operand_ready_i,
  input logic            vinsn_done_i,
  input logic            ldu_req_i,
  input logic            ldu_gnt_i
);

  // Store element held while the port stalls
  stu_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stu_operand_valid_i && !stu_operand_ready_i |=>
      stu_operand_valid_i && $stable(stu_operand_i))
    else $error("store operand changed while stalled");

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vinsn_done_i |=> !vinsn_done_i)
    else $error("vinsn_done_o high for two cycles");

  ldu_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldu_gnt_i |-> ldu_req_i)
    else $error("ldu_gnt_o without ldu_req_i");

endmodule

`default_nettype wire

// ==== sources.f ====
hw/lane_pkg.sv
hw/lane_fifo.sv
hw/lane_sequencer.sv
hw/operand_requester.sv
hw/vector_regfile.sv
hw/lane_alu.sv
hw/lane.sv
sim/tb_lane_sva.sv
sim/tb_lane.sv
